// File: hdl/dense_pkg.sv
package dense_pkg;

    // neuron count or index within a layer
    typedef logic [15:0] len_t;

    // word address into buffer 1 or buffer 2
    typedef logic [15:0] addr_t;

    // output block number, one block per N_PE neurons
    typedef logic [15:0] ob_t;

    // pe datapath latencies, in cycles
    localparam int LAT_MAC       = 2;
    localparam int LAT_DENSE_ADD = 1;
    localparam int LAT_BIAS_ADD  = 1;
    localparam int LAT_NL        = 2;

    // layer sequencer states
    typedef enum logic [1:0] {
        IDLE,
        BLOCK_SETUP, // pick next block or finish
        BLOCK_RUN    // reads, shifts and stages of one block
    } seq_state_t;

endpackage

// File: hdl/dense_block_sequencer.sv
`timescale 1ns/1ps

module dense_block_sequencer
    import dense_pkg::*;
#(
    parameter int N_PE = 8,
    localparam int LANE_W = $clog2(N_PE)
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  len_t            out_len,
    input  logic            latch_ready,
    input  logic            drain_busy,
    input  logic            drain_end,
    output logic            block_go,
    output logic            dense_latch,
    output logic            done,
    output logic            adder_clear,
    output ob_t             ob,
    output logic [N_PE-1:0] lane_mask
);

    seq_state_t state;

    ob_t              full_blk;   // blocks with all lanes used
    logic [LANE_W-1:0] rem;       // lanes in the partial block
    ob_t              blk_total;
    ob_t              nxt_ob;     // blocks launched so far
    logic             blocks_left;
    logic [N_PE-1:0]  part_mask;
    logic             pending;    // latch waiting for the drain

    assign full_blk  = ob_t'(out_len / N_PE);
    assign rem       = LANE_W'(out_len % N_PE);
    assign blk_total = full_blk + ob_t'(rem != '0);
    assign part_mask = ~({N_PE{1'b1}} << rem);

    assign blocks_left = (nxt_ob < blk_total);
    assign block_go    = (state == BLOCK_SETUP) && blocks_left;
    assign adder_clear = (state != BLOCK_RUN);

    // results leave the pe array once the drain can take them
    always_comb begin
        dense_latch = 1'b0;
        if (state == BLOCK_RUN) begin
            if (latch_ready && !drain_busy) begin
                dense_latch = 1'b1;
            end else if (pending && drain_end) begin
                dense_latch = 1'b1; // released by previous block's drain
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            nxt_ob    <= '0;
            ob        <= '0;
            lane_mask <= '0;
            pending   <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state  <= BLOCK_SETUP;
                        nxt_ob <= '0;
                    end
                end
                BLOCK_SETUP: begin
                    if (blocks_left) begin
                        state  <= BLOCK_RUN;
                        ob     <= nxt_ob;
                        nxt_ob <= nxt_ob + 1'b1;
                        // only the last block can be partial
                        lane_mask <= (nxt_ob == full_blk) ? part_mask : {N_PE{1'b1}};
                    end else if (!drain_busy) begin
                        state <= IDLE;
                        done  <= 1'b1;
                    end
                end
                BLOCK_RUN: begin
                    if (latch_ready && drain_busy) begin
                        pending <= 1'b1;
                    end
                    if (dense_latch) begin
                        pending <= 1'b0;
                        state   <= BLOCK_SETUP;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: hdl/dense_read_gen.sv
`timescale 1ns/1ps

module dense_read_gen
    import dense_pkg::*;
#(
    parameter int N_PE = 8
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            block_go,
    input  len_t            in_len,
    input  ob_t             ob,
    input  logic [N_PE-1:0] lane_mask,
    output logic [N_PE-1:0] wt_rd_en,
    output addr_t           wt_rd_addr,
    output logic            in_rd_en,
    output addr_t           in_rd_addr
);

    len_t  rd_idx;
    logic  rd_active;
    addr_t row_base;   // first weight word of this block

    // index runs 0..in_len, the last step fetches the bias word
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_active <= 1'b0;
            rd_idx    <= '0;
        end else if (block_go) begin
            rd_active <= 1'b1;
            rd_idx    <= '0;
        end else if (rd_active) begin
            if (rd_idx == in_len) begin
                rd_active <= 1'b0;
            end else begin
                rd_idx <= rd_idx + 1'b1;
            end
        end
    end

    // each neuron row holds in_len weights plus its bias
    assign row_base = (in_len + 16'd1) * ob;

    assign wt_rd_en   = rd_active ? lane_mask : '0;
    assign wt_rd_addr = row_base + rd_idx;

    // no input word goes with the bias
    assign in_rd_en   = rd_active && (rd_idx < in_len);
    assign in_rd_addr = rd_idx;

endmodule

// File: hdl/dense_stage_timer.sv
`timescale 1ns/1ps

module dense_stage_timer
    import dense_pkg::*;
#(
    parameter int N_PE = 8,
    parameter int DENSE_PER_GO = 4,
    localparam int DV_W = $clog2(DENSE_PER_GO + 1)
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            block_go,
    input  len_t            in_len,
    input  logic [N_PE-1:0] lane_mask,
    output logic [N_PE-1:0] wt_shift,
    output logic [N_PE-1:0] in_shift,
    output logic [N_PE-1:0] bias_shift,
    output logic [N_PE-1:0] mac_en,
    output logic [N_PE-1:0] acc_en,
    output logic [N_PE-1:0] bias_en,
    output logic [N_PE-1:0] nl_en,
    output logic [DV_W-1:0] dense_valid,
    output logic            latch_ready
);

    localparam int LAT_TOT = LAT_MAC + LAT_DENSE_ADD + LAT_BIAS_ADD + LAT_NL;

    logic [1:0]         go_d;      // block_go delayed 1 and 2 cycles
    len_t               sh_idx;
    logic               sh_active;
    len_t               mac_idx;
    logic               mac_active;
    len_t               mac_last;
    logic [DV_W-1:0]    grp_cnt;   // position inside current input group
    logic               mark_now;
    logic               last_mark;
    logic [LAT_MAC-1:0] mark_d;
    logic [LAT_TOT-1:0] last_d;

    assign mac_last = in_len + len_t'(LAT_MAC - 2);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            go_d       <= '0;
            sh_active  <= 1'b0;
            sh_idx     <= '0;
            mac_active <= 1'b0;
            mac_idx    <= '0;
        end else begin
            go_d <= {go_d[0], block_go};

            // shift window, one cycle behind the reads
            if (go_d[0]) begin
                sh_active <= 1'b1;
                sh_idx    <= '0;
            end else if (sh_active) begin
                if (sh_idx == in_len) begin
                    sh_active <= 1'b0;
                end else begin
                    sh_idx <= sh_idx + 1'b1;
                end
            end

            // mac window, extended to flush the mac pipe
            if (go_d[1]) begin
                mac_active <= 1'b1;
                mac_idx    <= '0;
            end else if (mac_active) begin
                if (mac_idx == mac_last) begin
                    mac_active <= 1'b0;
                end else begin
                    mac_idx <= mac_idx + 1'b1;
                end
            end
        end
    end

    assign wt_shift   = (sh_active && sh_idx < in_len) ? lane_mask : '0;
    assign in_shift   = (sh_active && sh_idx < in_len) ? lane_mask : '0;
    assign bias_shift = (sh_active && sh_idx == in_len) ? lane_mask : '0;
    assign mac_en     = mac_active ? lane_mask : '0;

    // a group closes on its DENSE_PER_GO-th input or on the last input
    assign last_mark = mac_active && (mac_idx == in_len - 1'b1);
    assign mark_now  = mac_active && (mac_idx < in_len) &&
                       ((grp_cnt == DV_W'(DENSE_PER_GO - 1)) || last_mark);
    assign dense_valid = mark_now ? grp_cnt + 1'b1 : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grp_cnt <= '0;
            mark_d  <= '0;
            last_d  <= '0;
        end else begin
            if (go_d[1]) begin
                grp_cnt <= '0;
            end else if (mac_active && mac_idx < in_len) begin
                grp_cnt <= mark_now ? '0 : grp_cnt + 1'b1;
            end
            mark_d <= {mark_d[LAT_MAC-2:0], mark_now};
            last_d <= {last_d[LAT_TOT-2:0], last_mark};
        end
    end

    // accumulate each group, then bias, nl and latch once per block
    assign acc_en  = mark_d[LAT_MAC-1] ? lane_mask : '0;
    assign bias_en = last_d[LAT_MAC+LAT_DENSE_ADD-1] ? lane_mask : '0;
    assign nl_en   = last_d[LAT_MAC+LAT_DENSE_ADD+LAT_BIAS_ADD-1] ? lane_mask : '0;
    assign latch_ready = last_d[LAT_TOT-1];

endmodule

// File: hdl/dense_drain.sv
`timescale 1ns/1ps

module dense_drain
    import dense_pkg::*;
#(
    parameter int N_PE = 8,
    localparam int LANE_W = $clog2(N_PE)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              dense_latch,
    input  ob_t               ob,
    input  logic [N_PE-1:0]   lane_mask,
    output logic              out_wr_en,
    output addr_t             out_wr_addr,
    output logic [LANE_W-1:0] drain_lane,
    output logic              drain_busy,
    output logic              drain_end
);

    ob_t               ob_q;       // block being drained
    logic [LANE_W-1:0] last_lane;
    logic [LANE_W-1:0] lane_count_m1;

    // lane mask is always contiguous from lane 0
    assign lane_count_m1 = LANE_W'($countones(lane_mask) - 1);

    // payload of the latched block
    always_ff @(posedge clk) begin
        if (dense_latch) begin
            ob_q      <= ob;
            last_lane <= lane_count_m1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            drain_busy <= 1'b0;
            drain_lane <= '0;
            drain_end  <= 1'b0;
        end else begin
            drain_end <= 1'b0;
            if (dense_latch) begin
                drain_busy <= 1'b1;
                drain_lane <= '0;
            end else if (drain_busy) begin
                if (drain_lane == last_lane) begin // also covers a 1-lane block
                    drain_busy <= 1'b0;
                    drain_lane <= '0;
                    drain_end  <= 1'b1;
                end else begin
                    drain_lane <= drain_lane + 1'b1;
                end
            end
        end
    end

    // one buffer-2 word per cycle, lane order
    assign out_wr_en   = drain_busy;
    assign out_wr_addr = addr_t'(ob_q * N_PE) + addr_t'(drain_lane);

endmodule

// File: hdl/dense_ctrl.sv
`timescale 1ns/1ps

module dense_ctrl
    import dense_pkg::*;
#(
    parameter int N_PE = 8,
    parameter int DENSE_PER_GO = 4,
    localparam int LANE_W = $clog2(N_PE),
    localparam int DV_W = $clog2(DENSE_PER_GO + 1)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  len_t              out_len,
    input  len_t              in_len,
    output logic [N_PE-1:0]   wt_rd_en,
    output addr_t             wt_rd_addr,
    output logic              in_rd_en,
    output addr_t             in_rd_addr,
    output logic [N_PE-1:0]   wt_shift,
    output logic [N_PE-1:0]   in_shift,
    output logic [N_PE-1:0]   bias_shift,
    output logic [N_PE-1:0]   mac_en,
    output logic [DV_W-1:0]   dense_valid,
    output logic [N_PE-1:0]   acc_en,
    output logic [N_PE-1:0]   bias_en,
    output logic [N_PE-1:0]   nl_en,
    output logic              dense_latch,
    output logic              adder_clear,
    output logic              out_wr_en,
    output addr_t             out_wr_addr,
    output logic [LANE_W-1:0] drain_lane,
    output logic              done
);

    logic            block_go;
    logic            latch_ready;
    logic            drain_busy;
    logic            drain_end;
    ob_t             ob;
    logic [N_PE-1:0] lane_mask;

    dense_block_sequencer #(.N_PE(N_PE)) u_seq (
        .clk(clk), .rst(rst), .start(start), .out_len(out_len),
        .latch_ready(latch_ready), .drain_busy(drain_busy), .drain_end(drain_end),
        .block_go(block_go), .dense_latch(dense_latch), .done(done),
        .adder_clear(adder_clear), .ob(ob), .lane_mask(lane_mask)
    );

    dense_read_gen #(.N_PE(N_PE)) u_rd (
        .clk(clk), .rst(rst), .block_go(block_go), .in_len(in_len), .ob(ob),
        .lane_mask(lane_mask), .wt_rd_en(wt_rd_en), .wt_rd_addr(wt_rd_addr),
        .in_rd_en(in_rd_en), .in_rd_addr(in_rd_addr)
    );

    dense_stage_timer #(.N_PE(N_PE), .DENSE_PER_GO(DENSE_PER_GO)) u_stage (
        .clk(clk), .rst(rst), .block_go(block_go), .in_len(in_len),
        .lane_mask(lane_mask), .wt_shift(wt_shift), .in_shift(in_shift),
        .bias_shift(bias_shift), .mac_en(mac_en), .acc_en(acc_en),
        .bias_en(bias_en), .nl_en(nl_en), .dense_valid(dense_valid),
        .latch_ready(latch_ready)
    );

    dense_drain #(.N_PE(N_PE)) u_drain (
        .clk(clk), .rst(rst), .dense_latch(dense_latch), .ob(ob),
        .lane_mask(lane_mask), .out_wr_en(out_wr_en), .out_wr_addr(out_wr_addr),
        .drain_lane(drain_lane), .drain_busy(drain_busy), .drain_end(drain_end)
    );

endmodule

// File: tb/dense_ctrl_props.sv
`timescale 1ns/1ps

module dense_ctrl_props
    import dense_pkg::*;
#(
    parameter int N_PE = 8,
    parameter int DENSE_PER_GO = 4,
    localparam int LANE_W = $clog2(N_PE),
    localparam int DV_W = $clog2(DENSE_PER_GO + 1)
) (
    input logic              clk,
    input logic              rst,
    input logic              start,
    input len_t              out_len,
    input len_t              in_len,
    input logic [N_PE-1:0]   wt_rd_en,
    input addr_t             wt_rd_addr,
    input logic              in_rd_en,
    input addr_t             in_rd_addr,
    input logic [N_PE-1:0]   wt_shift,
    input logic [N_PE-1:0]   in_shift,
    input logic [N_PE-1:0]   bias_shift,
    input logic [N_PE-1:0]   mac_en,
    input logic [DV_W-1:0]   dense_valid,
    input logic [N_PE-1:0]   acc_en,
    input logic [N_PE-1:0]   bias_en,
    input logic [N_PE-1:0]   nl_en,
    input logic              dense_latch,
    input logic              adder_clear,
    input logic              out_wr_en,
    input addr_t             out_wr_addr,
    input logic [LANE_W-1:0] drain_lane,
    input logic              drain_busy,
    input logic              done
);

    addr_t next_wr;   // next expected write address in the layer
    addr_t prev_rd;   // last weight read address
    len_t  dv_sum;    // group sizes marked in the current block
    logic  started;

    // lanes of the block that a weight address belongs to
    function automatic logic [N_PE-1:0] block_mask(addr_t rd_addr, len_t n_in, len_t n_out);
        int              first_neuron;
        int              i;
        logic [N_PE-1:0] m;
        first_neuron = (int'(rd_addr) / (int'(n_in) + 1)) * N_PE;
        m = '0;
        for (i = 0; i < N_PE; i++) begin
            if (first_neuron + i < int'(n_out))
                m[i] = 1'b1;
        end
        return m;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            next_wr <= '0;
            prev_rd <= '1;
            dv_sum  <= '0;
            started <= 1'b0;
        end else begin
            if (start) begin
                started <= 1'b1;
                next_wr <= '0;
                prev_rd <= '1; // first read of a layer is address 0
            end
            if (out_wr_en)
                next_wr <= next_wr + 16'd1;
            if (wt_rd_en != '0)
                prev_rd <= wt_rd_addr;
            if (bias_en != '0)
                dv_sum <= '0;
            else
                dv_sum <= dv_sum + len_t'(dense_valid);
        end
    end

    wr_addr_ok: assert property (@(posedge clk) disable iff (rst)
        out_wr_en |-> (out_wr_addr == next_wr) && (out_wr_addr < out_len))
        else $error("buffer-2 write address out of order or beyond out_len");

    lane_ok: assert property (@(posedge clk) disable iff (rst)
        out_wr_en |-> (drain_lane == LANE_W'(out_wr_addr % N_PE)))
        else $error("drain lane does not match the write address");

    latch_to_wr: assert property (@(posedge clk) disable iff (rst)
        dense_latch |=> out_wr_en && (drain_lane == '0))
        else $error("drain did not start writing the cycle after the latch");

    rd_mask_ok: assert property (@(posedge clk) disable iff (rst)
        (wt_rd_en != '0) |-> (wt_rd_en == block_mask(wt_rd_addr, in_len, out_len)))
        else $error("weight read lane mask does not match the block");

    rd_step_ok: assert property (@(posedge clk) disable iff (rst)
        (wt_rd_en != '0) |-> (wt_rd_addr == prev_rd + 16'd1))
        else $error("weight read address skipped or repeated");

    in_rd_ok: assert property (@(posedge clk) disable iff (rst)
        in_rd_en |-> (in_rd_addr < in_len) && (in_rd_addr == wt_rd_addr % (in_len + 16'd1)))
        else $error("input read address beyond in_len or off the weight row");

    // the bias word is the last read of a row and has no input word
    in_rd_en_ok: assert property (@(posedge clk) disable iff (rst)
        in_rd_en == ((wt_rd_en != '0) && (wt_rd_addr % (in_len + 16'd1) != in_len)))
        else $error("input read enable does not match the weight reads");

    shift_ok: assert property (@(posedge clk) disable iff (rst)
        (wt_shift == $past(in_rd_en ? wt_rd_en : '0)) &&
        (in_shift == $past(in_rd_en ? wt_rd_en : '0)) &&
        (bias_shift == $past(in_rd_en ? '0 : wt_rd_en)))
        else $error("shift strobes not one cycle behind the reads");

    // with LAT_MAC of 2 the mac window is as long as the read window
    mac_ok: assert property (@(posedge clk) disable iff (rst)
        mac_en == $past(wt_rd_en, 2))
        else $error("mac enable not two cycles behind the reads");

    dv_size_ok: assert property (@(posedge clk) disable iff (rst)
        dense_valid <= DV_W'(DENSE_PER_GO))
        else $error("dense group mark larger than a group");

    dv_sum_ok: assert property (@(posedge clk) disable iff (rst)
        (bias_en != '0) |-> (dv_sum == in_len))
        else $error("dense group marks of a block do not add up to in_len");

    bias_after_acc: assert property (@(posedge clk) disable iff (rst)
        (bias_en != '0) |-> ($past(acc_en, LAT_DENSE_ADD) == bias_en) && (acc_en == '0))
        else $error("bias enable not aligned to the last accumulate");

    nl_after_bias: assert property (@(posedge clk) disable iff (rst)
        nl_en == $past(bias_en, LAT_BIAS_ADD))
        else $error("nl enable not aligned to bias enable");

    done_ok: assert property (@(posedge clk) disable iff (rst)
        done |-> !out_wr_en && !drain_busy && (next_wr == out_len))
        else $error("done while draining or before the last write");

    idle_ok: assert property (@(posedge clk) disable iff (rst)
        !started |-> !done && !out_wr_en && (wt_rd_en == '0) && !dense_latch && adder_clear)
        else $error("controller not idle after reset");

endmodule

// File: tb/tb_dense_ctrl.sv
`timescale 1ns/1ps

module tb_dense_ctrl;

    localparam int N_PE = 8;
    localparam int DENSE_PER_GO = 4;
    localparam int LANE_W = $clog2(N_PE);
    localparam int DV_W = $clog2(DENSE_PER_GO + 1);
    localparam int N_LAYERS = 6;
    localparam int WATCHDOG_CYCLES = N_LAYERS * (20 * 40 + 50); // budget per layer at out_len 20

    logic              clk;
    logic              rst;
    logic              start;
    logic [15:0]       out_len;
    logic [15:0]       in_len;
    logic [N_PE-1:0]   wt_rd_en;
    logic [15:0]       wt_rd_addr;
    logic              in_rd_en;
    logic [15:0]       in_rd_addr;
    logic [N_PE-1:0]   wt_shift;
    logic [N_PE-1:0]   in_shift;
    logic [N_PE-1:0]   bias_shift;
    logic [N_PE-1:0]   mac_en;
    logic [DV_W-1:0]   dense_valid;
    logic [N_PE-1:0]   acc_en;
    logic [N_PE-1:0]   bias_en;
    logic [N_PE-1:0]   nl_en;
    logic              dense_latch;
    logic              adder_clear;
    logic              out_wr_en;
    logic [15:0]       out_wr_addr;
    logic [LANE_W-1:0] drain_lane;
    logic              done;

    int seed;
    int wr_total;     // buffer-2 writes since reset
    int done_total;

    dense_ctrl #(.N_PE(N_PE), .DENSE_PER_GO(DENSE_PER_GO)) UUT (
        .clk(clk), .rst(rst), .start(start), .out_len(out_len), .in_len(in_len),
        .wt_rd_en(wt_rd_en), .wt_rd_addr(wt_rd_addr), .in_rd_en(in_rd_en),
        .in_rd_addr(in_rd_addr), .wt_shift(wt_shift), .in_shift(in_shift),
        .bias_shift(bias_shift), .mac_en(mac_en), .dense_valid(dense_valid),
        .acc_en(acc_en), .bias_en(bias_en), .nl_en(nl_en), .dense_latch(dense_latch),
        .adder_clear(adder_clear), .out_wr_en(out_wr_en), .out_wr_addr(out_wr_addr),
        .drain_lane(drain_lane), .done(done)
    );

    // drain_busy is internal to the top level
    bind dense_ctrl dense_ctrl_props #(.N_PE(N_PE), .DENSE_PER_GO(DENSE_PER_GO)) u_props (
        .clk(clk), .rst(rst), .start(start), .out_len(out_len), .in_len(in_len),
        .wt_rd_en(wt_rd_en), .wt_rd_addr(wt_rd_addr), .in_rd_en(in_rd_en),
        .in_rd_addr(in_rd_addr), .wt_shift(wt_shift), .in_shift(in_shift),
        .bias_shift(bias_shift), .mac_en(mac_en), .dense_valid(dense_valid),
        .acc_en(acc_en), .bias_en(bias_en), .nl_en(nl_en), .dense_latch(dense_latch),
        .adder_clear(adder_clear), .out_wr_en(out_wr_en), .out_wr_addr(out_wr_addr),
        .drain_lane(drain_lane), .drain_busy(drain_busy), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst) begin
            wr_total   <= 0;
            done_total <= 0;
        end else begin
            if (out_wr_en)
                wr_total <= wr_total + 1;
            if (done)
                done_total <= done_total + 1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: layers did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $fatal(1);
    end

    task automatic check_count(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    // one start pulse, then wait for done and count what came out
    task automatic run_layer(input int idx, input int o_len, input int i_len);
        int wr_base;
        int done_base;
        @(negedge clk);
        out_len   = 16'(o_len);
        in_len    = 16'(i_len);
        wr_base   = wr_total;
        done_base = done_total;
        start     = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!done)
            @(negedge clk);
        repeat (3) @(negedge clk); // catch a stray second done
        check_count($sformatf("layer %0d writes", idx), o_len, wr_total - wr_base);
        check_count($sformatf("layer %0d done pulses", idx), 1, done_total - done_base);
    endtask

    initial begin
        int layer;
        int o_len;
        int i_len;
        seed    = 54;
        rst     = 1'b1;
        start   = 1'b0;
        out_len = '0;
        in_len  = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (5) @(negedge clk); // idle stretch before the first start

        for (layer = 0; layer < N_LAYERS; layer++) begin
            o_len = 1 + int'($unsigned($random(seed)) % 20);
            i_len = 1 + int'($unsigned($random(seed)) % 12);
            if (layer == 0)
                o_len = 1;   // single-lane block
            else if (layer == 1)
                o_len = 16;  // full blocks only
            else if (layer == 2)
                i_len = 3;   // shorter than one group
            $display("layer %0d: out_len %0d in_len %0d", layer, o_len, i_len);
            run_layer(layer, o_len, i_len);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: dense_ctrl.f
hdl/dense_pkg.sv
hdl/dense_block_sequencer.sv
hdl/dense_read_gen.sv
hdl/dense_stage_timer.sv
hdl/dense_drain.sv
hdl/dense_ctrl.sv
tb/dense_ctrl_props.sv
tb/tb_dense_ctrl.sv

// File: Makefile
.PHONY: sim clean

LOG := sim.log

sim:
	verilator --binary --assert --timing -j 0 --top-module tb_dense_ctrl \
		-f dense_ctrl.f -o sim_dense_ctrl
	./obj_dir/sim_dense_ctrl | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG) || ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
